/* sim.f */
cpuPkg.sv
ctrlPkg.sv
phaseIf.sv
instructionPhaseDecoder.sv
loadStoreGroupDecoder.sv
ldsControlUnit.sv
ldsControl_props.sv
ldsControlTb.sv

/* Bender.yml */
package:
  name: lds_control

sources:
  - cpuPkg.sv
  - ctrlPkg.sv
  - phaseIf.sv
  - instructionPhaseDecoder.sv
  - loadStoreGroupDecoder.sv
  - ldsControlUnit.sv
  - target: simulation
    files:
      - ldsControl_props.sv
      - ldsControlTb.sv

/* ldsControlTb.sv */
`timescale 1ns/100ps

module ldsControlTb;
	import cpuPkg::*;
	import ctrlPkg::*;

	localparam int clkPeriod   = 10;
	localparam int modeRepeats = 2;
	localparam int otherTests  = 8;
	localparam int holdCycles  = 3;
	localparam int resumeLimit = 4;
	// Mode sweep, other groups, halt pair and three debug instructions
	localparam int instrCount  = 2 * 7 * modeRepeats + otherTests + 5;
	localparam int testCycles  = 4 + 4 * instrCount + 3 * holdCycles + 2 * resumeLimit + 1;
	localparam int fieldBits   = $bits(regSeq) + $bits(aluOp) + $bits(aluASrc) + $bits(aluBSrc)
		+ $bits(addrBus) + $bits(dataBus) + $bits(regAAddr) + $bits(regBAddr);

	logic CLK = 1'b0;
	logic arstN;
	logic [15:0] din;
	logic halt;
	logic debugStop;
	logic debugStepReq;
	logic fetch;
	logic decode;
	logic execute;
	logic commit;
	logic stopped;
	logic pcEn;
	logic debugStepAck;
	logic [$bits(regSeq)-1:0]   regSeqX;
	logic [$bits(aluOp)-1:0]    aluOpX;
	logic [$bits(aluASrc)-1:0]  aluASrcX;
	logic [$bits(aluBSrc)-1:0]  aluBSrcX;
	logic [$bits(addrBus)-1:0]  addrBusX;
	logic [$bits(dataBus)-1:0]  dataBusX;
	logic [$bits(regAAddr)-1:0] regAAddrX;
	logic [$bits(regBAddr)-1:0] regBAddrX;
	logic [fieldBits-1:0] actual;
	logic [15:0] lfsrState = 16'd31581;

	ldsControlUnit i_ldsControlUnit (.*);

	always #(clkPeriod / 2) CLK = ~CLK;

	// All control fields as one vector for compare
	assign actual = {regSeqX, aluOpX, aluASrcX, aluBSrcX, addrBusX, dataBusX, regAAddrX, regBAddrX};

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
			lfsrState = {lfsrState[14:0], fb};
			val = {val[14:0], fb};
		end
		return val;
	endfunction

	function automatic logic [fieldBits-1:0] noneFields();
		return {seqNone, aluNone, srcANone, srcBNone, addrNone, dataNone, regANone, regBNone};
	endfunction

	// Load/store mode table
	function automatic logic [fieldBits-1:0] expectedFields(input logic [15:0] word);
		regSeq seq;
		aluASrc srcA;
		addrBus addr;
		dataBus data;
		regBAddr regB;
		if (word[15:13] != groupLoadStore) begin
			return noneFields();
		end
		seq = seqLdaRdb;
		srcA = srcAU5;
		addr = addrAluR;
		data = dataNone;
		regB = regBArgB;
		case (word[10:8])
			modeRegReg: begin
				srcA = srcARegA;
				addr = addrAlubData;
			end
			modeRegHere: begin
				seq = seqLdaImm;
				srcA = srcARegA;
				addr = addrHere;
			end
			modeRegRegDec: begin
				seq = seqLdaUpb;
				srcA = srcAMinusTwo;
			end
			modeRegRegInc: begin
				seq = seqLdaUpb;
				srcA = srcATwo;
				addr = addrAlubData;
			end
			modeRegFp: regB = regBFp;
			modeRegSp: regB = regBSp;
			default:   regB = regBRs;
		endcase
		if (word[12:11] == ldsSt) begin
			seq = seqRdaRdb;
			data = dataRegADout;
		end
		return {seq, aluAdd, srcA, srcBRegB, addr, data, regAArgA, regB};
	endfunction

	task automatic reportFailure(input string line);
		$display("%s", line);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// Checks a running cycle at the falling edge
	task automatic checkCycle(input string name, input logic [3:0] expStrobes,
		input logic [fieldBits-1:0] expFields, input logic expPcEn, input logic expAck);
		assert ({fetch, decode, execute, commit} == expStrobes)
			else reportFailure($sformatf("mismatch %s strobes expected %b actual %b", name,
				expStrobes, {fetch, decode, execute, commit}));
		assert (actual == expFields)
			else reportFailure($sformatf("mismatch %s fields expected %h actual %h", name,
				expFields, actual));
		assert (pcEn == expPcEn)
			else reportFailure($sformatf("mismatch %s pcEn expected %b actual %b", name,
				expPcEn, pcEn));
		assert (debugStepAck == expAck)
			else reportFailure($sformatf("mismatch %s debugStepAck expected %b actual %b", name,
				expAck, debugStepAck));
		assert (!stopped)
			else reportFailure($sformatf("mismatch %s stopped expected 0 actual %b", name, stopped));
	endtask

	task automatic checkStopped(input string name);
		assert (stopped)
			else reportFailure($sformatf("mismatch %s stopped expected 1 actual %b", name, stopped));
		assert ({fetch, decode, execute, commit, pcEn, debugStepAck} == 6'b0)
			else reportFailure($sformatf("mismatch %s strobes expected 000000 actual %b", name,
				{fetch, decode, execute, commit, pcEn, debugStepAck}));
		assert (actual == noneFields())
			else reportFailure($sformatf("mismatch %s fields expected %h actual %h", name,
				noneFields(), actual));
	endtask

	// Starts in the fetch cycle, ends one cycle after commit
	task automatic runInstr(input string name, input logic [15:0] word, input bit stopAfter,
		input bit ackExp);
		logic [fieldBits-1:0] exp;
		exp = expectedFields(word);
		checkCycle({name, " fetch"}, 4'b1000, noneFields(), 1'b0, 1'b0);
		din = word;
		@(negedge CLK);
		checkCycle({name, " decode"}, 4'b0100, noneFields(), 1'b0, 1'b0);
		@(negedge CLK);
		checkCycle({name, " execute"}, 4'b0010, exp, 1'b0, 1'b0);
		@(negedge CLK);
		checkCycle({name, " commit"}, 4'b0001, exp, 1'b1, ackExp);
		@(negedge CLK);
		if (stopAfter) begin
			checkStopped({name, " after commit"});
		end
	endtask

	task automatic holdStopped(input string name);
		repeat (holdCycles) begin
			@(negedge CLK);
			checkStopped(name);
		end
	endtask

	task automatic waitForFetch(input string name);
		int n;
		n = 0;
		do begin
			@(negedge CLK);
			n++;
		end while (!fetch && n < resumeLimit);
		assert (fetch)
			else reportFailure($sformatf("%s: fetch did not resume within %0d cycles", name,
				resumeLimit));
	endtask

	// Watchdog sized from the test list
	initial begin
		#(clkPeriod * (testCycles + 20));
		reportFailure("timeout: test sequence did not complete in time");
	end

	// Bound phase order checks end the run at their first failure
	initial begin
		wait (i_ldsControlUnit.i_instructionPhaseDecoder.i_phaseOrderProps.failCount != 0);
		reportFailure("phase order property failed");
	end

	initial begin
		logic [15:0] word;
		logic [15:0] bits;
		logic [2:0] grp;
		din = '0;
		halt = 1'b0;
		debugStop = 1'b0;
		debugStepReq = 1'b0;
		arstN = 1'b0;
		repeat (4) @(negedge CLK);
		arstN = 1'b1;
		checkCycle("reset", 4'b1000, noneFields(), 1'b0, 1'b0);

		// Every mode as load and store
		for (int op = 0; op < 2; op++) begin
			for (int m = 0; m < 7; m++) begin
				repeat (modeRepeats) begin
					bits = takeBits(8);
					word = {groupLoadStore, 2'(op), 3'(m), bits[7:0]};
					runInstr($sformatf("lds op%0d mode%0d", op, m), word, 1'b0, 1'b0);
				end
			end
		end

		// Other groups decode to idle
		for (int i = 0; i < otherTests; i++) begin
			bits = takeBits(3);
			grp = bits[2:0];
			if (grp == groupLoadStore) begin
				grp = groupJump;
			end
			bits = takeBits(13);
			word = {grp, bits[12:0]};
			runInstr($sformatf("other group %0d", i), word, 1'b0, 1'b0);
		end

		// Halt parks after commit
		word = {groupLoadStore, ldsLd, modeRegSp, 8'h3a};
		halt = 1'b1;
		runInstr("halt", word, 1'b1, 1'b0);
		holdStopped("halt hold");
		halt = 1'b0;
		waitForFetch("halt release");
		runInstr("halt resume", word, 1'b0, 1'b0);

		// Single step under debug stop
		debugStop = 1'b1;
		word = {groupLoadStore, ldsSt, modeRegFp, 8'h5c};
		runInstr("debug stop", word, 1'b1, 1'b0);
		holdStopped("debug hold");
		debugStepReq = 1'b1;
		@(negedge CLK);
		debugStepReq = 1'b0;
		runInstr("debug step", word, 1'b1, 1'b1);
		holdStopped("debug after step");
		debugStop = 1'b0;
		waitForFetch("debug release");
		runInstr("debug resume", word, 1'b0, 1'b0);

		$display("TEST OK");
		$finish;
	end

endmodule

/* ldsControl_props.sv */
`timescale 1ns/100ps

module phaseOrderProps (
	input logic                CLK,
	input logic                arstN,
	input ctrlPkg::phaseState  state,
	input logic                stopped,
	input logic                pcEn,
	input logic                debugStepAck
);
	import ctrlPkg::*;

	// Watched by the testbench while the run goes on
	int failCount = 0;

	// Held in fetch with all outputs idle while reset is low
	assert property (@(posedge CLK)
		!arstN |=> state == stFetch && !pcEn && !debugStepAck && !stopped)
		else begin
			failCount++;
			$error("sequencer not idle in fetch during reset");
		end

	// Fixed phase order
	assert property (@(posedge CLK) disable iff (!arstN) state == stFetch |=> state == stDecode)
		else begin
			failCount++;
			$error("decode did not follow fetch");
		end
	assert property (@(posedge CLK) disable iff (!arstN) state == stDecode |=> state == stExecute)
		else begin
			failCount++;
			$error("execute did not follow decode");
		end
	assert property (@(posedge CLK) disable iff (!arstN) state == stExecute |=> state == stCommit)
		else begin
			failCount++;
			$error("commit did not follow execute");
		end
	assert property (@(posedge CLK) disable iff (!arstN)
		state == stCommit |=> state == stFetch || state == stStopped)
		else begin
			failCount++;
			$error("commit left to a state other than fetch or stopped");
		end
	assert property (@(posedge CLK) disable iff (!arstN)
		state == stStopped |=> state == stStopped || state == stFetch)
		else begin
			failCount++;
			$error("stopped state left to a state other than fetch");
		end

endmodule

bind instructionPhaseDecoder phaseOrderProps i_phaseOrderProps (
	.CLK          (CLK),
	.arstN        (arstN),
	.state        (state),
	.stopped      (stopped),
	.pcEn         (pcEn),
	.debugStepAck (debugStepAck)
);

/* ldsControlUnit.sv */
`timescale 1ns/100ps

module ldsControlUnit (
	input  logic                                CLK,
	input  logic                                arstN,
	input  logic [$bits(cpuPkg::instrWord)-1:0] din,
	input  logic                                halt,
	input  logic                                debugStop,
	input  logic                                debugStepReq,
	output logic                                fetch,
	output logic                                decode,
	output logic                                execute,
	output logic                                commit,
	output logic                                stopped,
	output logic                                pcEn,
	output logic                                debugStepAck,
	output logic [$bits(ctrlPkg::regSeq)-1:0]   regSeqX,
	output logic [$bits(ctrlPkg::aluOp)-1:0]    aluOpX,
	output logic [$bits(ctrlPkg::aluASrc)-1:0]  aluASrcX,
	output logic [$bits(ctrlPkg::aluBSrc)-1:0]  aluBSrcX,
	output logic [$bits(ctrlPkg::addrBus)-1:0]  addrBusX,
	output logic [$bits(ctrlPkg::dataBus)-1:0]  dataBusX,
	output logic [$bits(ctrlPkg::regAAddr)-1:0] regAAddrX,
	output logic [$bits(ctrlPkg::regBAddr)-1:0] regBAddrX
);

	// Phase strobes and latched word
	phaseIf i_phase ();

	// Phase sequencer
	instructionPhaseDecoder i_instructionPhaseDecoder (
		.CLK          (CLK),
		.arstN        (arstN),
		.din          (din),
		.halt         (halt),
		.debugStop    (debugStop),
		.debugStepReq (debugStepReq),
		.phase        (i_phase),
		.stopped      (stopped),
		.pcEn         (pcEn),
		.debugStepAck (debugStepAck)
	);

	// Load/store fields go straight out, no control mux here
	loadStoreGroupDecoder i_loadStoreGroupDecoder (
		.CLK       (CLK),
		.arstN     (arstN),
		.phase     (i_phase),
		.regSeqX   (regSeqX),
		.aluOpX    (aluOpX),
		.aluASrcX  (aluASrcX),
		.aluBSrcX  (aluBSrcX),
		.addrBusX  (addrBusX),
		.dataBusX  (dataBusX),
		.regAAddrX (regAAddrX),
		.regBAddrX (regBAddrX)
	);

	// Strobes for the rest of the CPU
	assign fetch   = i_phase.fetch;
	assign decode  = i_phase.decode;
	assign execute = i_phase.execute;
	assign commit  = i_phase.commit;

endmodule

/* loadStoreGroupDecoder.sv */
`timescale 1ns/100ps

module loadStoreGroupDecoder (
	input  logic            CLK,
	input  logic            arstN,
	phaseIf.dec             phase,
	output ctrlPkg::regSeq   regSeqX,
	output ctrlPkg::aluOp    aluOpX,
	output ctrlPkg::aluASrc  aluASrcX,
	output ctrlPkg::aluBSrc  aluBSrcX,
	output ctrlPkg::addrBus  addrBusX,
	output ctrlPkg::dataBus  dataBusX,
	output ctrlPkg::regAAddr regAAddrX,
	output ctrlPkg::regBAddr regBAddrX
);
	import cpuPkg::*;
	import ctrlPkg::*;

	// Decoded fields before the register stage
	regSeq   nxtRegSeq;
	aluOp    nxtAluOp;
	aluASrc  nxtAluASrc;
	aluBSrc  nxtAluBSrc;
	addrBus  nxtAddrBus;
	dataBus  nxtDataBus;
	regAAddr nxtRegAAddr;
	regBAddr nxtRegBAddr;
	// Known addressing mode
	logic    modeValid;

	always_comb begin
		nxtRegSeq   = seqNone;
		nxtAluOp    = aluNone;
		nxtAluASrc  = srcANone;
		nxtAluBSrc  = srcBNone;
		nxtAddrBus  = addrNone;
		nxtDataBus  = dataNone;
		nxtRegAAddr = regANone;
		nxtRegBAddr = regBNone;
		modeValid   = 1'b1;

		// Mode specific fields
		case (phase.instruction.mode)
			modeRegReg: begin
				nxtRegSeq   = seqLdaRdb;
				nxtAluASrc  = srcARegA;
				nxtAddrBus  = addrAlubData;
				nxtRegBAddr = regBArgB;
			end
			modeRegHere: begin
				nxtRegSeq   = seqLdaImm;
				nxtAluASrc  = srcARegA;
				nxtAddrBus  = addrHere;
				nxtRegBAddr = regBArgB;
			end
			modeRegRegDec: begin
				// Pre-decrement, address taken from the ALU result
				nxtRegSeq   = seqLdaUpb;
				nxtAluASrc  = srcAMinusTwo;
				nxtAddrBus  = addrAluR;
				nxtRegBAddr = regBArgB;
			end
			modeRegRegInc: begin
				// Post-increment, address taken before the add
				nxtRegSeq   = seqLdaUpb;
				nxtAluASrc  = srcATwo;
				nxtAddrBus  = addrAlubData;
				nxtRegBAddr = regBArgB;
			end
			modeRegFp, modeRegSp, modeRegRs: begin
				// Pointer plus offset
				nxtRegSeq  = seqLdaRdb;
				nxtAluASrc = srcAU5;
				nxtAddrBus = addrAluR;
				if (phase.instruction.mode == modeRegFp) begin
					nxtRegBAddr = regBFp;
				end else if (phase.instruction.mode == modeRegSp) begin
					nxtRegBAddr = regBSp;
				end else begin
					nxtRegBAddr = regBRs;
				end
			end
			default: modeValid = 1'b0;
		endcase

		// Common to every load/store
		nxtAluOp    = aluAdd;
		nxtAluBSrc  = srcBRegB;
		nxtRegAAddr = regAArgA;

		// Store reads Ra and drives it onto the data bus
		if (phase.instruction.op == ldsSt) begin
			nxtRegSeq  = seqRdaRdb;
			nxtDataBus = dataRegADout;
		end

		// Other groups and unknown modes leave everything idle
		if ((phase.instruction.group != groupLoadStore) || !modeValid) begin
			nxtRegSeq   = seqNone;
			nxtAluOp    = aluNone;
			nxtAluASrc  = srcANone;
			nxtAluBSrc  = srcBNone;
			nxtAddrBus  = addrNone;
			nxtDataBus  = dataNone;
			nxtRegAAddr = regANone;
			nxtRegBAddr = regBNone;
		end
	end

	// Fields valid through execute and commit
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			regSeqX   <= seqNone;
			aluOpX    <= aluNone;
			aluASrcX  <= srcANone;
			aluBSrcX  <= srcBNone;
			addrBusX  <= addrNone;
			dataBusX  <= dataNone;
			regAAddrX <= regANone;
			regBAddrX <= regBNone;
		end else if (phase.decode) begin
			regSeqX   <= nxtRegSeq;
			aluOpX    <= nxtAluOp;
			aluASrcX  <= nxtAluASrc;
			aluBSrcX  <= nxtAluBSrc;
			addrBusX  <= nxtAddrBus;
			dataBusX  <= nxtDataBus;
			regAAddrX <= nxtRegAAddr;
			regBAddrX <= nxtRegBAddr;
		end else if (phase.commit) begin
			// Back to idle for the next fetch
			regSeqX   <= seqNone;
			aluOpX    <= aluNone;
			aluASrcX  <= srcANone;
			aluBSrcX  <= srcBNone;
			addrBusX  <= addrNone;
			dataBusX  <= dataNone;
			regAAddrX <= regANone;
			regBAddrX <= regBNone;
		end
	end

endmodule

/* instructionPhaseDecoder.sv */
`timescale 1ns/100ps

module instructionPhaseDecoder (
	input  logic            CLK,
	input  logic            arstN,
	input  cpuPkg::instrWord din,
	input  logic            halt,
	input  logic            debugStop,
	input  logic            debugStepReq,
	phaseIf.seq             phase,
	output logic            stopped,
	output logic            pcEn,
	output logic            debugStepAck
);
	import ctrlPkg::*;

	phaseState state;
	phaseState nextState;

	// Set by a step request, held until that instruction commits
	logic stepPending;
	logic stepStart;

	// Step only honored while parked under debug control
	assign stepStart = (state == stStopped) && debugStop && debugStepReq;

	always_comb begin
		nextState = state;
		unique case (state)
			stFetch:   nextState = stDecode;
			stDecode:  nextState = stExecute;
			stExecute: nextState = stCommit;
			stCommit: begin
				// Park after commit on halt or debug stop
				if (halt || debugStop) begin
					nextState = stStopped;
				end else begin
					nextState = stFetch;
				end
			end
			stStopped: begin
				if (stepStart || (!halt && !debugStop)) begin
					nextState = stFetch;
				end
			end
			default: nextState = stFetch;
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state       <= stFetch;
			stepPending <= 1'b0;
		end else begin
			state <= nextState;
			if (stepStart) begin
				stepPending <= 1'b1;
			end else if (state == stCommit) begin
				stepPending <= 1'b0;
			end
		end
	end

	// Instruction latch, loaded on the edge that ends fetch
	always_ff @(posedge CLK) begin
		if (state == stFetch) begin
			phase.instruction <= din;
		end
	end

	// One-hot phase strobes
	assign phase.fetch   = (state == stFetch);
	assign phase.decode  = (state == stDecode);
	assign phase.execute = (state == stExecute);
	assign phase.commit  = (state == stCommit);

	assign stopped      = (state == stStopped);
	// PC advances once per instruction
	assign pcEn         = (state == stCommit);
	assign debugStepAck = (state == stCommit) && stepPending;

endmodule

/* phaseIf.sv */
`timescale 1ns/100ps

interface phaseIf;
	import cpuPkg::*;

	// One-cycle phase strobes, at most one high
	logic fetch;
	logic decode;
	logic execute;
	logic commit;

	// Word latched at the end of fetch
	instrWord instruction;

	// Sequencer side
	modport seq (
		output fetch, decode, execute, commit, instruction
	);

	// Group decoder side
	modport dec (
		input fetch, decode, execute, commit, instruction
	);

endinterface

/* ctrlPkg.sv */
package ctrlPkg;

	// Register file access sequence
	typedef enum logic [3:0] {
		seqNone   = 4'd0,
		seqLdaRdb = 4'd1,
		seqLdaImm = 4'd2,
		seqLdaUpb = 4'd3,
		seqRdaRdb = 4'd4
	} regSeq;

	// ALU operation
	typedef enum logic [3:0] {
		aluNone = 4'd0,
		aluAdd  = 4'd1
	} aluOp;

	// ALU A operand source
	typedef enum logic [2:0] {
		srcANone     = 3'd0,
		srcARegA     = 3'd1,
		srcAMinusTwo = 3'd2,
		srcATwo      = 3'd3,
		// Zero-extended offset from argB
		srcAU5       = 3'd4
	} aluASrc;

	// ALU B operand source
	typedef enum logic [2:0] {
		srcBNone = 3'd0,
		srcBRegB = 3'd1
	} aluBSrc;

	// Address bus source
	typedef enum logic [2:0] {
		addrNone     = 3'd0,
		addrAlubData = 3'd1,
		addrHere     = 3'd2,
		addrAluR     = 3'd3
	} addrBus;

	// Data bus source
	typedef enum logic [1:0] {
		dataNone     = 2'd0,
		dataRegADout = 2'd1
	} dataBus;

	// Register file port B address select
	typedef enum logic [2:0] {
		regBNone = 3'd0,
		regBArgB = 3'd1,
		regBFp   = 3'd2,
		regBSp   = 3'd3,
		regBRs   = 3'd4
	} regBAddr;

	// Register file port A address select
	typedef enum logic [1:0] {
		regANone = 2'd0,
		regAArgA = 2'd1
	} regAAddr;

	// Sequencer state
	typedef enum logic [2:0] {
		stStopped = 3'd0,
		stFetch   = 3'd1,
		stDecode  = 3'd2,
		stExecute = 3'd3,
		stCommit  = 3'd4
	} phaseState;

endpackage

/* cpuPkg.sv */
package cpuPkg;

	// Instruction group in bits 15:13
	typedef enum logic [2:0] {
		groupGeneral   = 3'd0,
		groupLoadStore = 3'd1,
		groupJump      = 3'd2,
		groupAlu       = 3'd3,
		groupRegister  = 3'd4
	} instrGroup;

	// Load/store operation in bits 12:11
	typedef enum logic [1:0] {
		ldsLd = 2'd0,
		ldsSt = 2'd1
	} ldsOp;

	// Load/store addressing mode in bits 10:8
	typedef enum logic [2:0] {
		// (Rb)
		modeRegReg    = 3'd0,
		// (HERE)
		modeRegHere   = 3'd1,
		// (--Rb)
		modeRegRegDec = 3'd2,
		// (Rb++)
		modeRegRegInc = 3'd3,
		// Frame pointer plus unsigned offset
		modeRegFp     = 3'd4,
		// Stack pointer plus unsigned offset
		modeRegSp     = 3'd5,
		// Return stack plus unsigned offset
		modeRegRs     = 3'd6
	} ldsMode;

	// Register number, also used as a 4-bit offset in argB
	typedef logic [3:0] regNum;

	// Full 16-bit instruction word
	typedef struct packed {
		instrGroup group;
		ldsOp      op;
		ldsMode    mode;
		regNum     argA;
		regNum     argB;
	} instrWord;

	// Dedicated pointer registers
	localparam regNum regFp = 4'd12;
	localparam regNum regSp = 4'd13;
	localparam regNum regRs = 4'd14;

endpackage
